// ==== flist.f ====
rtl/mem_bridge_pkg.sv
rtl/axil_csr.sv
rtl/app_sequencer.sv
rtl/lane_packer.sv
rtl/mem_bridge_top.sv
sim/app_mem_model.sv
sim/tb_mem_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_mem_bridge -f flist.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_mem_bridge)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF '>>> PASS'; then
    exit 0
fi

echo "Simulation did not report a pass"
exit 1

// ==== sim/tb_mem_bridge.sv ====
`default_nettype none

module tb_mem_bridge
    import mem_bridge_pkg::*;
();

    localparam int MEM_ADDR_W  = 28;
    localparam int N_RANDOM    = 200;
    // Memory accesses made by tests 2 to 5, then the random ones
    localparam int N_ACCESS    = 2 + 7 + 6 + 3 + N_RANDOM;
    localparam int CYCLE_LIMIT = 200 * N_ACCESS;

    typedef logic [MEM_ADDR_W-2:0] burst_addr_t;

    logic                  ui_clk;
    logic                  ui_clk_sync_rst;
    axil_addr_t            s_awaddr;
    logic                  s_awvalid;
    logic                  s_awready;
    axil_data_t            s_wdata;
    axil_strb_t            s_wstrb;
    logic                  s_wvalid;
    logic                  s_wready;
    axil_resp_t            s_bresp;
    logic                  s_bvalid;
    logic                  s_bready;
    axil_addr_t            s_araddr;
    logic                  s_arvalid;
    logic                  s_arready;
    axil_data_t            s_rdata;
    axil_resp_t            s_rresp;
    logic                  s_rvalid;
    logic                  s_rready;
    logic [MEM_ADDR_W-2:0] app_addr;
    app_cmd_e              app_cmd;
    logic                  app_en;
    logic                  app_rdy;
    app_wdf_t              app_wdf;
    logic                  app_wdf_rdy;
    app_rd_t               app_rd;
    logic                  stall;

    logic [127:0] shadow [burst_addr_t];
    int           seed        = 5396;
    int           cycles      = 0;
    int           checks      = 0;
    int           errors      = 0;
    int           test_errors = 0;
    string        name_q[$];
    mem_data_t    got_q[$];
    mem_data_t    exp_q[$];
    string        cname;
    mem_data_t    cgot;
    mem_data_t    cexp;

    mem_bridge_top #(.MEM_ADDR_W(MEM_ADDR_W)) dut0 (.*);

    app_mem_model #(.ADDR_W(MEM_ADDR_W - 1)) mem0 (.*);

    initial begin
        ui_clk = 1'b0;
        forever begin
            #2 ui_clk = ~ui_clk;
        end
    end

    always @(posedge ui_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Compares queued results one per cycle
    always @(posedge ui_clk) begin
        if (got_q.size() > 0) begin
            cname = name_q.pop_front();
            cgot  = got_q.pop_front();
            cexp  = exp_q.pop_front();
            checks++;
            if (cgot !== cexp) begin
                errors++;
                $display("ERROR %s: got %h expected %h", cname, cgot, cexp);
            end
        end
    end

    // Same contents as the memory model holds for a burst never written
    function automatic logic [127:0] fill_burst(burst_addr_t a);
        logic [127:0] burst;
        logic [31:0]  a32;
        a32 = 32'(a);
        for (int b = 0; b < 16; b++) begin
            burst[8*b +: 8] = a32[7:0] ^ a32[15:8] ^ a32[23:16] ^ a32[31:24] ^ 8'(b * 37 + 5);
        end
        return burst;
    endfunction

    function automatic logic [127:0] shadow_burst(burst_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return fill_burst(a);
    endfunction

    // Register byte k, counted from the MSB, lives in burst byte (addr bit 0) + k
    task automatic shadow_write(mem_addr_t addr, access_width_e width, mem_data_t data);
        burst_addr_t  a;
        logic [127:0] burst;
        a     = addr[MEM_ADDR_W-1:1];
        burst = shadow_burst(a);
        for (int k = 0; k < (1 << int'(width)); k++) begin
            burst[8*(int'(addr[0]) + k) +: 8] = data[8*(7-k) +: 8];
        end
        shadow[a] = burst;
    endtask

    function automatic mem_data_t expected_read(mem_addr_t addr, access_width_e width);
        logic [127:0] burst;
        mem_data_t    result;
        burst  = shadow_burst(addr[MEM_ADDR_W-1:1]);
        result = '0;
        for (int k = 0; k < (1 << int'(width)); k++) begin
            result[8*(7-k) +: 8] = burst[8*(int'(addr[0]) + k) +: 8];
        end
        return result;
    endfunction

    function automatic axil_data_t ctrl_word(logic is_write, access_width_e width);
        axil_data_t ctrl;
        ctrl = 32'(width);
        ctrl[is_write ? CTRL_START_WR : CTRL_START_RD] = 1'b1;
        return ctrl;
    endfunction

    task automatic push_check(string name, mem_data_t got, mem_data_t exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    task automatic axil_write(axil_addr_t addr, axil_data_t data);
        @(negedge ui_clk);
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        #1;
        while (!s_awready) begin
            @(negedge ui_clk);
            #1;
        end
        push_check("wready", mem_data_t'(s_wready), 64'd1);
        @(negedge ui_clk);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        while (!s_bvalid) begin
            @(negedge ui_clk);
        end
        push_check("bresp", mem_data_t'(s_bresp), mem_data_t'(RESP_OKAY));
    endtask

    task automatic axil_read(axil_addr_t addr, output axil_data_t data);
        @(negedge ui_clk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        #1;
        while (!s_arready) begin
            @(negedge ui_clk);
            #1;
        end
        @(negedge ui_clk);
        s_arvalid = 1'b0;
        while (!s_rvalid) begin
            @(negedge ui_clk);
        end
        data = s_rdata;
        push_check("rresp", mem_data_t'(s_rresp), mem_data_t'(RESP_OKAY));
    endtask

    task automatic wait_done();
        axil_data_t r;
        r = '0;
        while (!r[CTRL_DONE]) begin
            axil_read(REG_CTRL, r);
        end
    endtask

    task automatic read_result(output mem_data_t value);
        axil_data_t lo;
        axil_data_t hi;
        axil_read(REG_RDATA_LO, lo);
        axil_read(REG_RDATA_HI, hi);
        value = {hi, lo};
    endtask

    task automatic run_access(logic is_write, mem_addr_t addr, access_width_e width,
                              mem_data_t data);
        axil_write(REG_ADDR, addr);
        if (is_write) begin
            axil_write(REG_WDATA_LO, data[31:0]);
            axil_write(REG_WDATA_HI, data[63:32]);
            shadow_write(addr, width, data);
        end
        axil_write(REG_CTRL, ctrl_word(is_write, width));
        wait_done();
    endtask

    task automatic check_read(mem_addr_t addr, access_width_e width);
        mem_data_t d;
        run_access(1'b0, addr, width, '0);
        read_result(d);
        push_check("rdata", d, expected_read(addr, width));
    endtask

    task automatic report_test(int num, string name);
        while (got_q.size() != 0) begin
            @(negedge ui_clk);
        end
        if (errors == test_errors) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        axil_data_t    r;
        mem_data_t     d;
        mem_addr_t     addr;
        access_width_e width;
        logic          is_wr;
        ui_clk_sync_rst = 1'b1;
        s_awaddr        = '0;
        s_awvalid       = 1'b0;
        s_wdata         = '0;
        s_wstrb         = 4'hF;
        s_wvalid        = 1'b0;
        s_bready        = 1'b1;
        s_araddr        = '0;
        s_arvalid       = 1'b0;
        s_rready        = 1'b1;
        stall           = 1'b0;
        repeat (4) @(negedge ui_clk);
        ui_clk_sync_rst = 1'b0;

        axil_read(REG_CTRL, r);
        push_check("ctrl.busy", mem_data_t'(r[CTRL_BUSY]), '0);
        push_check("ctrl.done", mem_data_t'(r[CTRL_DONE]), '0);
        read_result(d);
        push_check("rdata", d, '0);
        report_test(1, "reset values");

        run_access(1'b1, 32'h100, WIDTH_64, 64'h0123_4567_89AB_CDEF);
        check_read(32'h100, WIDTH_64);
        read_result(d);
        push_check("rdata", d, 64'h0123_4567_89AB_CDEF);
        report_test(2, "64-bit write and read at even address");

        // Bytes 1 to 8 of the burst, so the last one spills into the second beat
        run_access(1'b1, 32'h1235, WIDTH_64, 64'hFEDC_BA98_7654_3210);
        check_read(32'h1234, WIDTH_8);
        check_read(32'h1235, WIDTH_8);
        check_read(32'h1236, WIDTH_8);
        check_read(32'h1237, WIDTH_8);
        check_read(32'h1235, WIDTH_16);
        check_read(32'h1235, WIDTH_64);
        report_test(3, "64-bit write at odd address");

        run_access(1'b1, 32'h2000, WIDTH_64, 64'h1111_2222_3333_4444);
        run_access(1'b1, 32'h2001, WIDTH_32, 64'hA1A2_A3A4_5566_7788);
        run_access(1'b1, 32'h2000, WIDTH_16, 64'hB1B2_B3B4_B5B6_B7B8);
        run_access(1'b1, 32'h2001, WIDTH_8, 64'hC1C2_C3C4_C5C6_C7C8);
        check_read(32'h2000, WIDTH_64);
        check_read(32'h2001, WIDTH_64);
        report_test(4, "narrow write masks");

        // The model holds off the command so the second start lands while busy
        run_access(1'b1, 32'h3000, WIDTH_64, 64'h0F1E_2D3C_4B5A_6978);
        stall = 1'b1;
        axil_write(REG_ADDR, 32'h3000);
        axil_write(REG_CTRL, ctrl_word(1'b0, WIDTH_64));
        axil_write(REG_WDATA_LO, 32'h5A5A_5A5A);
        axil_write(REG_CTRL, ctrl_word(1'b1, WIDTH_8));
        axil_read(REG_CTRL, r);
        push_check("ctrl.busy", mem_data_t'(r[CTRL_BUSY]), 64'd1);
        push_check("ctrl.width", mem_data_t'(r[1:0]), mem_data_t'(WIDTH_64));
        stall = 1'b0;
        wait_done();
        read_result(d);
        push_check("rdata", d, expected_read(32'h3000, WIDTH_64));
        axil_read(REG_WDATA_LO, r);
        push_check("wdata_lo", mem_data_t'(r), 64'h0000_0000_4B5A_6978);
        report_test(5, "start while busy is ignored");

        for (int i = 0; i < N_RANDOM; i++) begin
            addr  = 32'h4000 + ($unsigned($random(seed)) & 32'h3F);
            width = access_width_e'(2'($random(seed)));
            is_wr = 1'($random(seed));
            d     = {32'($random(seed)), 32'($random(seed))};
            if (is_wr) begin
                run_access(1'b1, addr, width, d);
            end else begin
                check_read(addr, width);
            end
        end
        report_test(6, "random accesses");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/app_mem_model.sv ====
`default_nettype none

module app_mem_model
    import mem_bridge_pkg::*;
#(
    parameter int ADDR_W = 27
) (
    input  wire logic              ui_clk,
    input  wire logic              ui_clk_sync_rst,
    input  wire logic              stall,
    input  wire logic [ADDR_W-1:0] app_addr,
    input  wire app_cmd_e          app_cmd,
    input  wire logic              app_en,
    output logic                   app_rdy,
    input  wire app_wdf_t          app_wdf,
    output logic                   app_wdf_rdy,
    output app_rd_t                app_rd
);

    typedef logic [ADDR_W-1:0] burst_addr_t;

    // One 16-byte burst per app address, burst byte b sits at bits 8*b
    logic [127:0] mem [burst_addr_t];

    int           seed = 5396;
    burst_addr_t  wr_addr;
    burst_addr_t  rd_addr;
    int           rd_wait;
    int           rd_left;
    logic         hold;
    logic [127:0] rd_burst;

    // Bursts that were never written return a pattern built from the whole address
    function automatic logic [127:0] fill_burst(burst_addr_t a);
        logic [127:0] burst;
        logic [31:0]  a32;
        a32 = 32'(a);
        for (int b = 0; b < 16; b++) begin
            burst[8*b +: 8] = a32[7:0] ^ a32[15:8] ^ a32[23:16] ^ a32[31:24] ^ 8'(b * 37 + 5);
        end
        return burst;
    endfunction

    function automatic logic [127:0] load_burst(burst_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_burst(a);
    endfunction

    // The beat with the end flag carries burst bytes 8 to 15
    task automatic store_beat(app_wdf_t beat);
        logic [127:0] burst;
        int           base;
        burst = load_burst(wr_addr);
        base  = beat.data_end ? 8 : 0;
        for (int b = 0; b < 8; b++) begin
            if (!beat.mask[b]) begin
                burst[8*(base + b) +: 8] = beat.data[8*b +: 8];
            end
        end
        mem[wr_addr] = burst;
    endtask

    initial begin
        app_rdy     = 1'b0;
        app_wdf_rdy = 1'b0;
        app_rd      = '0;
        rd_wait     = 0;
        rd_left     = 0;
        hold        = 1'b0;
        forever begin
            // Handshakes use the values present at the rising edge
            @(posedge ui_clk);
            hold = stall;
            if (ui_clk_sync_rst) begin
                rd_left = 0;
            end else begin
                if (app_en && app_rdy) begin
                    if (app_cmd == CMD_WRITE) begin
                        wr_addr = app_addr;
                    end else begin
                        rd_addr = app_addr;
                        rd_left = 2;
                        rd_wait = 1 + int'($unsigned($random(seed)) % 6);
                    end
                end
                if (app_wdf.wren && app_wdf_rdy) begin
                    store_beat(app_wdf);
                end
            end
            @(negedge ui_clk);
            app_rdy     = !ui_clk_sync_rst && !hold && ($random(seed) % 4 != 0);
            app_wdf_rdy = !ui_clk_sync_rst && ($random(seed) % 3 != 0);
            app_rd      = '0;
            if (rd_left > 0) begin
                if (rd_wait > 1) begin
                    rd_wait--;
                end else begin
                    rd_burst        = load_burst(rd_addr);
                    app_rd.data     = (rd_left == 2) ? rd_burst[63:0] : rd_burst[127:64];
                    app_rd.valid    = 1'b1;
                    app_rd.data_end = (rd_left == 1);
                    rd_left--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_bridge_top.sv ====
`default_nettype none

module mem_bridge_top
    import mem_bridge_pkg::*;
#(
    parameter int MEM_ADDR_W = 28
) (
    input  wire logic             ui_clk,
    input  wire logic             ui_clk_sync_rst,

    input  wire axil_addr_t       s_awaddr,
    input  wire logic             s_awvalid,
    output logic                  s_awready,
    input  wire axil_data_t       s_wdata,
    input  wire axil_strb_t       s_wstrb,
    input  wire logic             s_wvalid,
    output logic                  s_wready,
    output axil_resp_t            s_bresp,
    output logic                  s_bvalid,
    input  wire logic             s_bready,
    input  wire axil_addr_t       s_araddr,
    input  wire logic             s_arvalid,
    output logic                  s_arready,
    output axil_data_t            s_rdata,
    output axil_resp_t            s_rresp,
    output logic                  s_rvalid,
    input  wire logic             s_rready,

    output logic [MEM_ADDR_W-2:0] app_addr,
    output app_cmd_e              app_cmd,
    output logic                  app_en,
    input  wire logic             app_rdy,
    output app_wdf_t              app_wdf,
    input  wire logic             app_wdf_rdy,
    input  wire app_rd_t          app_rd
);

    mem_req_t   req;
    logic       start_rd;
    logic       start_wr;
    logic       complete;
    mem_data_t  rdata;
    logic       beat_sel;
    mem_data_t  beat_data;
    byte_mask_t beat_mask;

    axil_csr #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) csr0 (
        .ui_clk          (ui_clk),
        .ui_clk_sync_rst (ui_clk_sync_rst),
        .s_awaddr        (s_awaddr),
        .s_awvalid       (s_awvalid),
        .s_awready       (s_awready),
        .s_wdata         (s_wdata),
        .s_wstrb         (s_wstrb),
        .s_wvalid        (s_wvalid),
        .s_wready        (s_wready),
        .s_bresp         (s_bresp),
        .s_bvalid        (s_bvalid),
        .s_bready        (s_bready),
        .s_araddr        (s_araddr),
        .s_arvalid       (s_arvalid),
        .s_arready       (s_arready),
        .s_rdata         (s_rdata),
        .s_rresp         (s_rresp),
        .s_rvalid        (s_rvalid),
        .s_rready        (s_rready),
        .req             (req),
        .start_rd        (start_rd),
        .start_wr        (start_wr),
        .complete        (complete),
        .rdata           (rdata)
    );

    app_sequencer #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) seq0 (
        .ui_clk          (ui_clk),
        .ui_clk_sync_rst (ui_clk_sync_rst),
        .req             (req),
        .start_rd        (start_rd),
        .start_wr        (start_wr),
        .complete        (complete),
        .app_addr        (app_addr),
        .app_cmd         (app_cmd),
        .app_en          (app_en),
        .app_rdy         (app_rdy),
        .app_wdf         (app_wdf),
        .app_wdf_rdy     (app_wdf_rdy),
        .app_rd          (app_rd),
        .beat_sel        (beat_sel),
        .beat_data       (beat_data),
        .beat_mask       (beat_mask)
    );

    lane_packer packer0 (
        .ui_clk          (ui_clk),
        .ui_clk_sync_rst (ui_clk_sync_rst),
        .req             (req),
        .beat_sel        (beat_sel),
        .beat_data       (beat_data),
        .beat_mask       (beat_mask),
        .app_rd          (app_rd),
        .rdata           (rdata)
    );

endmodule

`default_nettype wire

// ==== rtl/lane_packer.sv ====
`default_nettype none

module lane_packer
    import mem_bridge_pkg::*;
(
    input  wire logic      ui_clk,
    input  wire logic      ui_clk_sync_rst,

    input  wire mem_req_t  req,
    input  wire logic      beat_sel,
    output mem_data_t      beat_data,
    output byte_mask_t     beat_mask,

    input  wire app_rd_t   app_rd,
    output mem_data_t      rdata
);

    int        n_bytes;
    int        byte_ofs;
    mem_data_t rd_next;

    // Register byte carried by one lane of one beat, or -1 when that burst byte is unused.
    // Register byte 0 is the most significant one and lands on burst byte ofs.
    function automatic int reg_byte(logic beat, int lane, int ofs, int n);
        int k;
        k = 8 * int'(beat) + lane - ofs;
        if (k < 0 || k >= n) begin
            return -1;
        end
        return k;
    endfunction

    assign n_bytes  = width_bytes(req.width);
    assign byte_ofs = int'(req.addr[0]);

    always_comb begin
        int k;
        k         = 0;
        beat_data = '0;
        beat_mask = '1;
        for (int lane = 0; lane < 8; lane++) begin
            k = reg_byte(beat_sel, lane, byte_ofs, n_bytes);
            if (k >= 0) begin
                beat_data[8*lane +: 8] = req.wdata[8*(7-k) +: 8];
                beat_mask[lane]        = 1'b0;
            end
        end
    end

    // The first beat starts a fresh result and the second one adds its spill bytes
    always_comb begin
        int k;
        k       = 0;
        rd_next = app_rd.data_end ? rdata : '0;
        for (int lane = 0; lane < 8; lane++) begin
            k = reg_byte(app_rd.data_end, lane, byte_ofs, n_bytes);
            if (k >= 0) begin
                rd_next[8*(7-k) +: 8] = app_rd.data[8*lane +: 8];
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (ui_clk_sync_rst) begin
            rdata <= '0;
        end else if (app_rd.valid) begin
            rdata <= rd_next;
        end
    end

    // The controller never flags the last beat without data behind it
    assert property (@(posedge ui_clk) disable iff (ui_clk_sync_rst)
        app_rd.data_end |-> app_rd.valid)
        else $error("app_rd end flag without valid");

endmodule

`default_nettype wire

// ==== rtl/app_sequencer.sv ====
`default_nettype none

module app_sequencer
    import mem_bridge_pkg::*;
#(
    parameter int MEM_ADDR_W = 28
) (
    input  wire logic             ui_clk,
    input  wire logic             ui_clk_sync_rst,

    input  wire mem_req_t         req,
    input  wire logic             start_rd,
    input  wire logic             start_wr,
    output logic                  complete,

    output logic [MEM_ADDR_W-2:0] app_addr,
    output app_cmd_e              app_cmd,
    output logic                  app_en,
    input  wire logic             app_rdy,
    output app_wdf_t              app_wdf,
    input  wire logic             app_wdf_rdy,
    input  wire app_rd_t          app_rd,

    output logic                  beat_sel,
    input  wire mem_data_t        beat_data,
    input  wire byte_mask_t       beat_mask
);

    typedef enum logic [2:0] {
        IDLE,
        CMD_WR,
        WDATA_FIRST,
        WDATA_SECOND,
        CMD_RD,
        RD_WAIT
    } state_e;

    state_e     state;
    logic       wdf_load;
    logic       rd_last;
    mem_data_t  wdf_data;
    byte_mask_t wdf_mask;
    logic       wdf_wren;
    logic       wdf_end;

    // The app port addresses 16-bit units, so bit 0 only steers the lanes
    assign app_addr = req.addr[MEM_ADDR_W-1:1];

    // The packer shows the beat that is loaded next
    assign beat_sel = (state == WDATA_FIRST);

    // Capture strobe for the outgoing write beat
    assign wdf_load = (state == CMD_WR && app_rdy) || (state == WDATA_FIRST && app_wdf_rdy);

    assign rd_last = app_rd.valid && app_rd.data_end;

    assign app_wdf = '{data: wdf_data, mask: wdf_mask, wren: wdf_wren, data_end: wdf_end};

    always_ff @(posedge ui_clk) begin
        if (wdf_load) begin
            wdf_data <= beat_data;
            wdf_mask <= beat_mask;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (ui_clk_sync_rst) begin
            state    <= IDLE;
            app_en   <= 1'b0;
            app_cmd  <= CMD_WRITE;
            wdf_wren <= 1'b0;
            wdf_end  <= 1'b0;
            complete <= 1'b0;
        end else begin
            complete <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_wr) begin
                        app_en  <= 1'b1;
                        app_cmd <= CMD_WRITE;
                        state   <= CMD_WR;
                    end else if (start_rd) begin
                        app_en  <= 1'b1;
                        app_cmd <= CMD_READ;
                        state   <= CMD_RD;
                    end
                end
                // Write data only starts once the command queue has taken the command
                CMD_WR: begin
                    if (app_rdy) begin
                        app_en   <= 1'b0;
                        wdf_wren <= 1'b1;
                        state    <= WDATA_FIRST;
                    end
                end
                WDATA_FIRST: begin
                    if (app_wdf_rdy) begin
                        wdf_end <= 1'b1;
                        state   <= WDATA_SECOND;
                    end
                end
                WDATA_SECOND: begin
                    if (app_wdf_rdy) begin
                        wdf_wren <= 1'b0;
                        wdf_end  <= 1'b0;
                        complete <= 1'b1;
                        state    <= IDLE;
                    end
                end
                CMD_RD: begin
                    if (app_rdy) begin
                        app_en <= 1'b0;
                        // Both beats can already be back by the time the command is taken
                        if (rd_last) begin
                            complete <= 1'b1;
                            state    <= IDLE;
                        end else begin
                            state <= RD_WAIT;
                        end
                    end
                end
                RD_WAIT: begin
                    if (rd_last) begin
                        complete <= 1'b1;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assert property (@(posedge ui_clk) disable iff (ui_clk_sync_rst)
        app_en && !app_rdy |=> app_en)
        else $error("app_en dropped before app_rdy");

    assert property (@(posedge ui_clk) disable iff (ui_clk_sync_rst)
        app_wdf.wren && !app_wdf_rdy |=> $stable(app_wdf))
        else $error("app_wdf changed while the beat was stalled");

endmodule

`default_nettype wire

// ==== rtl/axil_csr.sv ====
`default_nettype none

module axil_csr
    import mem_bridge_pkg::*;
#(
    parameter int MEM_ADDR_W = 28
) (
    input  wire logic       ui_clk,
    input  wire logic       ui_clk_sync_rst,

    input  wire axil_addr_t s_awaddr,
    input  wire logic       s_awvalid,
    output logic            s_awready,
    input  wire axil_data_t s_wdata,
    input  wire axil_strb_t s_wstrb,
    input  wire logic       s_wvalid,
    output logic            s_wready,
    output axil_resp_t      s_bresp,
    output logic            s_bvalid,
    input  wire logic       s_bready,
    input  wire axil_addr_t s_araddr,
    input  wire logic       s_arvalid,
    output logic            s_arready,
    output axil_data_t      s_rdata,
    output axil_resp_t      s_rresp,
    output logic            s_rvalid,
    input  wire logic       s_rready,

    output mem_req_t        req,
    output logic            start_rd,
    output logic            start_wr,
    input  wire logic       complete,
    input  wire mem_data_t  rdata
);

    // Bytes above the supported address range always read back as zero
    localparam mem_addr_t ADDR_MASK = mem_addr_t'((64'd1 << MEM_ADDR_W) - 64'd1);

    logic          wr_fire;
    logic          rd_fire;
    logic          start_req;
    logic          busy;
    logic          done;
    mem_addr_t     addr_q;
    access_width_e width_q;
    mem_data_t     wdata_q;
    axil_data_t    rd_value;

    function automatic axil_data_t merge_strb(axil_data_t old_val, axil_data_t new_val,
                                              axil_strb_t strb);
        axil_data_t result;
        result = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return result;
    endfunction

    // Address and data are taken together, and only once the last response has gone
    assign wr_fire   = s_awvalid && s_wvalid && !s_bvalid;
    assign s_awready = wr_fire;
    assign s_wready  = wr_fire;
    assign s_arready = s_arvalid && !s_rvalid;
    assign rd_fire   = s_arready;
    assign s_bresp   = RESP_OKAY;
    assign s_rresp   = RESP_OKAY;

    // Start bits live in byte 0 of CTRL
    assign start_req = wr_fire && !busy && s_awaddr == REG_CTRL && s_wstrb[0]
                       && (s_wdata[CTRL_START_RD] || s_wdata[CTRL_START_WR]);

    assign req = '{addr: addr_q, width: width_q, wdata: wdata_q};

    always_ff @(posedge ui_clk) begin
        if (ui_clk_sync_rst) begin
            s_bvalid <= 1'b0;
        end else if (wr_fire) begin
            s_bvalid <= 1'b1;
        end else if (s_bready) begin
            s_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (ui_clk_sync_rst) begin
            s_rvalid <= 1'b0;
        end else if (rd_fire) begin
            s_rvalid <= 1'b1;
        end else if (s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    always_comb begin
        rd_value = '0;
        case (s_araddr)
            REG_ADDR: rd_value = axil_data_t'(addr_q);
            REG_CTRL: begin
                rd_value[CTRL_WIDTH_MSB:CTRL_WIDTH_LSB] = width_q;
                rd_value[CTRL_BUSY]                     = busy;
                rd_value[CTRL_DONE]                     = done;
            end
            REG_WDATA_LO: rd_value = wdata_q[31:0];
            REG_WDATA_HI: rd_value = wdata_q[63:32];
            REG_RDATA_LO: rd_value = rdata[31:0];
            REG_RDATA_HI: rd_value = rdata[63:32];
            default:      rd_value = '0;
        endcase
    end

    always_ff @(posedge ui_clk) begin
        if (rd_fire) begin
            s_rdata <= rd_value;
        end
    end

    // The request is frozen for as long as an access is running
    always_ff @(posedge ui_clk) begin
        if (ui_clk_sync_rst) begin
            addr_q  <= '0;
            width_q <= WIDTH_8;
        end else if (wr_fire && !busy) begin
            if (s_awaddr == REG_ADDR) begin
                addr_q <= merge_strb(addr_q, s_wdata, s_wstrb) & ADDR_MASK;
            end
            if (s_awaddr == REG_CTRL && s_wstrb[0]) begin
                width_q <= access_width_e'(s_wdata[CTRL_WIDTH_MSB:CTRL_WIDTH_LSB]);
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (wr_fire && !busy) begin
            case (s_awaddr)
                REG_WDATA_LO: wdata_q[31:0]  <= merge_strb(wdata_q[31:0], s_wdata, s_wstrb);
                REG_WDATA_HI: wdata_q[63:32] <= merge_strb(wdata_q[63:32], s_wdata, s_wstrb);
                default: ;
            endcase
        end
    end

    always_ff @(posedge ui_clk) begin
        if (ui_clk_sync_rst) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            start_rd <= 1'b0;
            start_wr <= 1'b0;
        end else begin
            start_rd <= 1'b0;
            start_wr <= 1'b0;
            if (start_req) begin
                busy     <= 1'b1;
                done     <= 1'b0;
                // A write wins when both start bits are set
                start_wr <= s_wdata[CTRL_START_WR];
                start_rd <= !s_wdata[CTRL_START_WR];
            end else if (complete) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // The sequencer only finishes an access that was started here
    assert property (@(posedge ui_clk) disable iff (ui_clk_sync_rst) complete |-> busy)
        else $error("complete pulse while no access is busy");

endmodule

`default_nettype wire

// ==== rtl/mem_bridge_pkg.sv ====
`default_nettype none

package mem_bridge_pkg;

    // The ADDR register is one 32-bit CSR, so no access can reach beyond this
    localparam int MAX_ADDR_W = 32;

    typedef logic [MAX_ADDR_W-1:0] mem_addr_t;
    typedef logic [63:0]           mem_data_t;
    typedef logic [7:0]            byte_mask_t;

    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        WIDTH_8  = 2'd0,
        WIDTH_16 = 2'd1,
        WIDTH_32 = 2'd2,
        WIDTH_64 = 2'd3
    } access_width_e;

    typedef enum logic [2:0] {
        CMD_WRITE = 3'd0,
        CMD_READ  = 3'd1
    } app_cmd_e;

    typedef struct packed {
        mem_addr_t     addr;
        access_width_e width;
        mem_data_t     wdata;
    } mem_req_t;

    // A set mask bit leaves that byte of the burst unchanged in memory
    typedef struct packed {
        mem_data_t  data;
        byte_mask_t mask;
        logic       wren;
        logic       data_end;
    } app_wdf_t;

    typedef struct packed {
        mem_data_t data;
        logic      valid;
        logic      data_end;
    } app_rd_t;

    localparam axil_addr_t REG_ADDR     = 8'h00;
    localparam axil_addr_t REG_CTRL     = 8'h04;
    localparam axil_addr_t REG_WDATA_LO = 8'h08;
    localparam axil_addr_t REG_WDATA_HI = 8'h0C;
    localparam axil_addr_t REG_RDATA_LO = 8'h10;
    localparam axil_addr_t REG_RDATA_HI = 8'h14;

    // Bit positions inside CTRL
    localparam int CTRL_WIDTH_LSB = 0;
    localparam int CTRL_WIDTH_MSB = 1;
    localparam int CTRL_START_RD  = 4;
    localparam int CTRL_START_WR  = 5;
    localparam int CTRL_BUSY      = 8;
    localparam int CTRL_DONE      = 9;

    function automatic int width_bytes(access_width_e width);
        return 1 << int'(width);
    endfunction

endpackage

`default_nettype wire
